// File: flist.f
+incdir+rtl
rtl/mx_pkg.sv
rtl/mx_buf_if.sv
rtl/block_collector.sv
rtl/block_buffer.sv
rtl/element_quantizer.sv
rtl/fp16_to_mxint.sv
verif/fp16_to_mxint_checker.sv
verif/tb_fp16_to_mxint.sv

// File: verif/tb_fp16_to_mxint.sv
`timescale 1ns/1ps

`include "mx_params.svh"

module tb_fp16_to_mxint;

	localparam int N = `MX_BLOCK_SIZE;
	localparam int CLK_PERIOD = 10;
	localparam int RESET_CYCLES = 8;
	localparam int RANDOM_BLOCKS = 5;
	localparam int EDGE_BLOCKS = 4;
	localparam int STALL_BLOCKS = 2;
	localparam int TOGGLE_BLOCKS = 6;
	localparam int TOTAL_BLOCKS = RANDOM_BLOCKS + EDGE_BLOCKS + STALL_BLOCKS + TOGGLE_BLOCKS;
	localparam int TIMEOUT_CYCLES = TOTAL_BLOCKS * 200 + RESET_CYCLES;
	localparam logic [31:0] SEED = 32'h85c4_792e;
	localparam int READY_HIGH = 0;
	localparam int READY_LOW = 1;
	localparam int READY_RANDOM = 2;

	typedef logic [`MX_ELEM_W-1:0] word_t;
	typedef word_t block_t [N];
	typedef logic signed [`MX_ELEM_W-1:0] qblock_t [N];

	logic                         CLK;
	logic                         RSTN;
	logic                         in_valid;
	logic                         in_ready;
	word_t                        in_data;
	logic                         out_valid;
	logic                         out_ready;
	logic signed [`MX_ELEM_W-1:0] out_data;
	logic signed [`MX_EXP_W:0]    out_shared_exp;
	logic                         out_last;

	logic [31:0] stim_lfsr;
	logic [31:0] ready_lfsr;
	int          ready_mode;
	int          blocks_rcvd;
	word_t       sent_q [$];

	fp16_to_mxint u_dut (
		.CLK            (CLK),
		.RSTN           (RSTN),
		.in_valid       (in_valid),
		.in_ready       (in_ready),
		.in_data        (in_data),
		.out_valid      (out_valid),
		.out_ready      (out_ready),
		.out_data       (out_data),
		.out_shared_exp (out_shared_exp),
		.out_last       (out_last)
	);

	bind fp16_to_mxint fp16_to_mxint_checker u_checker (.*);

	// galois form with feedback taps 32, 22, 2 and 1.
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	task automatic draw_bits(inout logic [31:0] st, input int n, output logic [31:0] r);
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], st[0]};
			st = lfsr_step(st);
		end
	endtask

	// the expected integer is the significand with its hidden one and sign, shifted by
	// the exponent field minus the block maximum plus the scale shift.
	function automatic void ref_block(input block_t blk, output qblock_t q,
		output logic signed [`MX_EXP_W:0] sexp);
		int max_e;
		int e;
		int sig;
		int sh;
		max_e = 0;
		for (int i = 0; i < N; i++) begin
			e = int'(blk[i][14:10]);
			if (e > max_e) begin
				max_e = e;
			end
		end
		sexp = max_e - `MX_FP16_BIAS;
		for (int i = 0; i < N; i++) begin
			e = int'(blk[i][14:10]);
			sig = int'(blk[i][9:0]);
			if (e != 0) begin
				sig = sig + (1 << `MX_MANT_W);
			end
			if (blk[i][15]) begin
				sig = -sig;
			end
			sh = e - max_e + `MX_SCALE_SHIFT;
			if (sh >= 0) begin
				sig = sig << sh;
			end else begin
				sig = sig >>> (-sh);
			end
			q[i] = sig[`MX_ELEM_W-1:0];
		end
	endfunction

	task automatic fail_stop();
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped on the first error");
	endtask

	task automatic check_value(input string what, input logic signed [31:0] got,
		input logic signed [31:0] expected);
		if (got !== expected) begin
			$display("MISMATCH at %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
			fail_stop();
		end
	endtask

	task automatic make_random_block(output block_t blk);
		logic [31:0] r;
		for (int i = 0; i < N; i++) begin
			draw_bits(stim_lfsr, 16, r);
			blk[i] = r[15:0];
		end
	endtask

	task automatic make_edge_block(input int kind, output block_t blk);
		logic [31:0] r;
		logic [4:0]  small_e;
		for (int i = 0; i < N; i++) begin
			draw_bits(stim_lfsr, 16, r);
			small_e = 5'd1 + r[14:13];
			case (kind)
				0: blk[i] = '0;
				// even slots are subnormal.
				1: blk[i] = {r[15], (i % 2 == 1) ? small_e : 5'd0, r[9:0]};
				2: blk[i] = (i == 7) ? {r[15], 5'd31, r[9:0]} : {r[15], 2'b01, r[12:10], r[9:0]};
				default: blk[i] = {r[15], 5'd20, r[9:0]};
			endcase
		end
	endtask

	// the beat is taken at the rising edge after this returns.
	task automatic send_elem(input word_t v);
		@(negedge CLK);
		in_valid = 1'b1;
		in_data = v;
		while (!in_ready) begin
			@(negedge CLK);
		end
		sent_q.push_back(v);
	endtask

	task automatic send_block(input block_t blk);
		for (int i = 0; i < N; i++) begin
			send_elem(blk[i]);
		end
	endtask

	task automatic fill_until_stall(output int accepted);
		logic [31:0] r;
		accepted = 0;
		@(negedge CLK);
		while (in_ready && accepted < 4 * N) begin
			draw_bits(stim_lfsr, 16, r);
			in_valid = 1'b1;
			in_data = r[15:0];
			sent_q.push_back(r[15:0]);
			accepted++;
			@(negedge CLK);
		end
		in_valid = 1'b0;
	endtask

	initial begin
		CLK = 1'b0;
		forever #(CLK_PERIOD / 2) CLK = ~CLK;
	end

	initial begin : watchdog
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("timeout: only %0d of %0d blocks came out", blocks_rcvd, TOTAL_BLOCKS);
		fail_stop();
	end

	initial begin : assertion_watch
		wait (u_dut.u_checker.fail_count != 0);
		$display("an assertion of the bound checker failed at %0t ns", $time);
		fail_stop();
	end

	// owns out_ready and checks every beat that is taken at the next rising edge.
	initial begin : output_side
		block_t                    blk;
		qblock_t                   q;
		logic signed [`MX_EXP_W:0] sexp;
		logic [31:0]               r;
		int                        idx;
		idx = 0;
		blocks_rcvd = 0;
		out_ready = 1'b1;
		forever begin
			@(negedge CLK);
			case (ready_mode)
				READY_LOW: out_ready = 1'b0;
				READY_RANDOM: begin
					draw_bits(ready_lfsr, 1, r);
					out_ready = r[0];
				end
				default: out_ready = 1'b1;
			endcase
			if (out_valid && out_ready) begin
				if (idx == 0) begin
					if (sent_q.size() < N) begin
						$display("output started before a whole input block was accepted");
						fail_stop();
					end else begin
						for (int i = 0; i < N; i++) begin
							blk[i] = sent_q.pop_front();
						end
						ref_block(blk, q, sexp);
					end
				end
				check_value($sformatf("block %0d elem %0d data", blocks_rcvd, idx),
					out_data, q[idx]);
				check_value($sformatf("block %0d shared exp", blocks_rcvd), out_shared_exp, sexp);
				check_value($sformatf("block %0d elem %0d last", blocks_rcvd, idx),
					out_last, idx == N - 1);
				idx++;
				if (idx == N) begin
					idx = 0;
					blocks_rcvd++;
				end
			end
		end
	end

	initial begin : main_flow
		block_t blk;
		int     accepted;
		int     target;
		RSTN = 1'b0;
		in_valid = 1'b0;
		in_data = '0;
		stim_lfsr = SEED;
		ready_lfsr = SEED;
		ready_mode = READY_HIGH;
		repeat (RESET_CYCLES) @(negedge CLK);
		RSTN = 1'b1;
		@(negedge CLK);
		check_value("out_valid after reset", out_valid, 0);
		check_value("in_ready after reset", in_ready, 1);

		for (int b = 0; b < RANDOM_BLOCKS; b++) begin
			make_random_block(blk);
			send_block(blk);
		end
		for (int k = 0; k < EDGE_BLOCKS; k++) begin
			make_edge_block(k, blk);
			send_block(blk);
		end
		@(negedge CLK);
		in_valid = 1'b0;
		target = RANDOM_BLOCKS + EDGE_BLOCKS;
		wait (blocks_rcvd == target);

		// with nothing leaving, both banks fill and the input stalls.
		@(posedge CLK);
		ready_mode = READY_LOW;
		fill_until_stall(accepted);
		check_value("elements accepted before the stall", accepted, STALL_BLOCKS * N);
		@(posedge CLK);
		ready_mode = READY_HIGH;
		target = target + STALL_BLOCKS;
		wait (blocks_rcvd == target);

		@(posedge CLK);
		ready_mode = READY_RANDOM;
		for (int b = 0; b < TOGGLE_BLOCKS; b++) begin
			make_random_block(blk);
			send_block(blk);
		end
		@(negedge CLK);
		in_valid = 1'b0;
		target = target + TOGGLE_BLOCKS;
		wait (blocks_rcvd == target);
		@(negedge CLK);

		// after the last block nothing is left over and no further beat is offered.
		if (sent_q.size() == 0 && !out_valid) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			$display("output did not end cleanly: %0d elements left and out_valid is %0b",
				sent_q.size(), out_valid);
			fail_stop();
		end
	end

endmodule

// File: verif/fp16_to_mxint_checker.sv
`timescale 1ns/1ps

`include "mx_params.svh"

module fp16_to_mxint_checker (
	input logic                         CLK,
	input logic                         RSTN,
	input logic                         in_valid,
	input logic                         in_ready,
	input logic [`MX_ELEM_W-1:0]        in_data,
	input logic                         out_valid,
	input logic                         out_ready,
	input logic signed [`MX_ELEM_W-1:0] out_data,
	input logic signed [`MX_EXP_W:0]    out_shared_exp,
	input logic                         out_last
);
	int unsigned fail_count = 0;

	// a beat that is not taken stays on the port unchanged.
	a_out_hold: assert property (@(posedge CLK) disable iff (!RSTN)
		out_valid && !out_ready |=> out_valid && $stable(out_data)
			&& $stable(out_shared_exp) && $stable(out_last))
	else begin
		fail_count++;
		$error("output beat changed while stalled");
	end

	a_reset_idle: assert property (@(posedge CLK) !RSTN |-> !out_valid)
	else begin
		fail_count++;
		$error("out_valid high during reset");
	end

	a_in_hold: assert property (@(posedge CLK) disable iff (!RSTN)
		in_valid && !in_ready |=> $stable(in_data))
	else begin
		fail_count++;
		$error("in_data changed while the input was stalled");
	end

endmodule

// File: rtl/fp16_to_mxint.sv
`timescale 1ns/1ps

`include "mx_params.svh"

module fp16_to_mxint (
	input  logic                        CLK,
	input  logic                        RSTN,
	input  logic                        in_valid,
	output logic                        in_ready,
	input  logic [`MX_ELEM_W-1:0]       in_data,
	output logic                        out_valid,
	input  logic                        out_ready,
	output logic signed [`MX_ELEM_W-1:0] out_data,
	output logic signed [`MX_EXP_W:0]   out_shared_exp,
	output logic                        out_last
);
	import mx_pkg::*;

	logic       blk_valid;
	logic       blk_ready;
	bank_t      blk_bank;
	exp_field_t blk_exp;
	logic       bank_free;
	bank_t      bank_free_id;

	mx_buf_if u_buf_if ();

	block_collector u_collector (
		.CLK          (CLK),
		.RSTN         (RSTN),
		.in_valid     (in_valid),
		.in_ready     (in_ready),
		.in_data      (in_data),
		.buf_if       (u_buf_if.writer),
		.blk_valid    (blk_valid),
		.blk_ready    (blk_ready),
		.blk_bank     (blk_bank),
		.blk_exp      (blk_exp),
		.bank_free    (bank_free),
		.bank_free_id (bank_free_id)
	);

	block_buffer u_buffer (
		.CLK    (CLK),
		.buf_if (u_buf_if.buffer)
	);

	element_quantizer u_quantizer (
		.CLK            (CLK),
		.RSTN           (RSTN),
		.buf_if         (u_buf_if.reader),
		.blk_valid      (blk_valid),
		.blk_ready      (blk_ready),
		.blk_bank       (blk_bank),
		.blk_exp        (blk_exp),
		.bank_free      (bank_free),
		.bank_free_id   (bank_free_id),
		.out_valid      (out_valid),
		.out_ready      (out_ready),
		.out_data       (out_data),
		.out_shared_exp (out_shared_exp),
		.out_last       (out_last)
	);

endmodule

// File: rtl/element_quantizer.sv
`timescale 1ns/1ps

`include "mx_params.svh"

module element_quantizer (
	input  logic                CLK,
	input  logic                RSTN,
	mx_buf_if.reader            buf_if,
	input  logic                blk_valid,
	output logic                blk_ready,
	input  mx_pkg::bank_t       blk_bank,
	input  mx_pkg::exp_field_t  blk_exp,
	output logic                bank_free,
	output mx_pkg::bank_t       bank_free_id,
	output logic                out_valid,
	input  logic                out_ready,
	output mx_pkg::mx_elem_t    out_data,
	output mx_pkg::shared_exp_t out_shared_exp,
	output logic                out_last
);
	import mx_pkg::*;

	localparam elem_idx_t LAST_IDX = elem_idx_t'(`MX_BLOCK_SIZE - 1);

	logic       active;
	logic       issuing;
	bank_t      cur_bank;
	exp_field_t cur_exp;
	elem_idx_t  ptr;
	logic       s1_valid;
	logic       s1_last;
	logic       advance;
	logic       issue;

	// aligns one element to the shared exponent and treats exponent field 31 like any other.
	function automatic mx_elem_t align_elem(input fp16_t v, input exp_field_t shared);
		logic [`MX_MANT_W:0]        sig;
		mx_elem_t                   val;
		logic signed [`MX_EXP_W+1:0] sh;
		sig = {v.exp != '0, v.mant};
		val = mx_elem_t'(sig);
		if (v.sign) begin
			val = -val;
		end
		sh = $signed({2'b00, v.exp}) - $signed({2'b00, shared}) + `MX_SCALE_SHIFT;
		if (sh >= 0) begin
			return val <<< sh;
		end
		return val >>> (-sh);
	endfunction

	assign advance = !out_valid || out_ready;
	assign issue = issuing && advance;
	assign blk_ready = !active;
	assign bank_free = out_valid && out_ready && out_last;
	assign bank_free_id = cur_bank;

	// on a stall the previous address is presented again so rd_data holds.
	assign buf_if.rd_bank = cur_bank;
	assign buf_if.rd_idx = advance ? ptr : ptr - 1'b1;

	always_ff @(posedge CLK or negedge RSTN) begin
		if (!RSTN) begin
			active <= 1'b0;
			issuing <= 1'b0;
			cur_bank <= 1'b0;
			ptr <= '0;
			s1_valid <= 1'b0;
			s1_last <= 1'b0;
			out_valid <= 1'b0;
			out_last <= 1'b0;
		end else begin
			if (blk_valid && blk_ready) begin
				active <= 1'b1;
				issuing <= 1'b1;
				cur_bank <= blk_bank;
				ptr <= '0;
			end else begin
				if (issue) begin
					ptr <= ptr + 1'b1;
					if (ptr == LAST_IDX) begin
						issuing <= 1'b0;
					end
				end
				if (bank_free) begin
					active <= 1'b0;
				end
			end
			if (advance) begin
				s1_valid <= issue;
				s1_last <= issue && (ptr == LAST_IDX);
				out_valid <= s1_valid;
				out_last <= s1_valid && s1_last;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (blk_valid && blk_ready) begin
			cur_exp <= blk_exp;
		end
		if (advance && s1_valid) begin
			out_data <= align_elem(buf_if.rd_data, cur_exp);
			out_shared_exp <= shared_exp_t'($signed({1'b0, cur_exp}) - `MX_FP16_BIAS);
		end
	end

endmodule

// File: rtl/block_buffer.sv
`timescale 1ns/1ps

`include "mx_params.svh"

module block_buffer (
	input  logic      CLK,
	mx_buf_if.buffer  buf_if
);
	import mx_pkg::*;

	localparam int NUM_BANKS = 2;

	// the writer and the reader always work on different banks.
	fp16_t mem [NUM_BANKS][`MX_BLOCK_SIZE];

	always_ff @(posedge CLK) begin
		if (buf_if.wr_en) begin
			mem[buf_if.wr_bank][buf_if.wr_idx] <= buf_if.wr_data;
		end
	end

	// the read is registered, so data follows the address by one cycle.
	always_ff @(posedge CLK) begin
		buf_if.rd_data <= mem[buf_if.rd_bank][buf_if.rd_idx];
	end

endmodule

// File: rtl/block_collector.sv
`timescale 1ns/1ps

`include "mx_params.svh"

module block_collector (
	input  logic               CLK,
	input  logic               RSTN,
	input  logic               in_valid,
	output logic               in_ready,
	input  mx_pkg::fp16_t      in_data,
	mx_buf_if.writer           buf_if,
	output logic               blk_valid,
	input  logic               blk_ready,
	output mx_pkg::bank_t      blk_bank,
	output mx_pkg::exp_field_t blk_exp,
	input  logic               bank_free,
	input  mx_pkg::bank_t      bank_free_id
);
	import mx_pkg::*;

	localparam elem_idx_t LAST_IDX = elem_idx_t'(`MX_BLOCK_SIZE - 1);

	elem_idx_t  elem_idx;
	bank_t      cur_bank;
	logic [1:0] busy;
	exp_field_t exp_max;
	exp_field_t exp_max_nxt;
	logic       accept;
	logic       blk_done;

	// banks are freed in the order they were posted, so the bank being filled
	// can only be busy when the other one is busy too.
	assign in_ready = !busy[cur_bank];
	assign accept = in_valid && in_ready;
	assign blk_done = accept && (elem_idx == LAST_IDX);

	assign buf_if.wr_en = accept;
	assign buf_if.wr_bank = cur_bank;
	assign buf_if.wr_idx = elem_idx;
	assign buf_if.wr_data = in_data;

	// the first element of a block restarts the running maximum.
	always_comb begin
		exp_max_nxt = in_data.exp;
		if (elem_idx != '0 && exp_max > in_data.exp) begin
			exp_max_nxt = exp_max;
		end
	end

	always_ff @(posedge CLK or negedge RSTN) begin
		if (!RSTN) begin
			elem_idx <= '0;
			cur_bank <= 1'b0;
			busy <= 2'b00;
			blk_valid <= 1'b0;
		end else begin
			if (accept) begin
				elem_idx <= elem_idx + 1'b1;
			end
			if (bank_free) begin
				busy[bank_free_id] <= 1'b0;
			end
			if (blk_done) begin
				busy[cur_bank] <= 1'b1;
				cur_bank <= !cur_bank;
			end
			// only one descriptor can be pending because the quantizer goes idle
			// before the other bank can fill up again.
			if (blk_done) begin
				blk_valid <= 1'b1;
			end else if (blk_ready) begin
				blk_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (accept) begin
			exp_max <= exp_max_nxt;
		end
		if (blk_done) begin
			blk_bank <= cur_bank;
			blk_exp <= exp_max_nxt;
		end
	end

endmodule

// File: rtl/mx_buf_if.sv
`timescale 1ns/1ps

interface mx_buf_if;
	import mx_pkg::*;

	logic      wr_en;
	bank_t     wr_bank;
	elem_idx_t wr_idx;
	fp16_t     wr_data;

	bank_t     rd_bank;
	elem_idx_t rd_idx;
	fp16_t     rd_data;

	modport writer (output wr_en, output wr_bank, output wr_idx, output wr_data);

	modport reader (output rd_bank, output rd_idx, input rd_data);

	modport buffer (
		input  wr_en,
		input  wr_bank,
		input  wr_idx,
		input  wr_data,
		input  rd_bank,
		input  rd_idx,
		output rd_data
	);

endinterface

// File: rtl/mx_pkg.sv
package mx_pkg;

`include "mx_params.svh"

	typedef struct packed {
		logic                  sign;
		logic [`MX_EXP_W-1:0]  exp;
		logic [`MX_MANT_W-1:0] mant;
	} fp16_t;

	typedef logic signed [`MX_ELEM_W-1:0] mx_elem_t;

	typedef logic [`MX_EXP_W-1:0] exp_field_t;

	// unbiased, so one bit wider than the field to hold -15 to +16.
	typedef logic signed [`MX_EXP_W:0] shared_exp_t;

	typedef logic bank_t;

	typedef logic [$clog2(`MX_BLOCK_SIZE)-1:0] elem_idx_t;

endpackage

// File: rtl/mx_params.svh
`ifndef MX_PARAMS_SVH
`define MX_PARAMS_SVH

// elements that share one exponent.
`define MX_BLOCK_SIZE 32

// FP16 layout is sign, exponent field, mantissa field.
`define MX_EXP_W 5
`define MX_MANT_W 10
`define MX_ELEM_W 16

`define MX_FP16_BIAS 15

// every element is moved this far left before the exponent difference is applied.
`define MX_SCALE_SHIFT 4

`endif
